// ==== video_pkg.sv ====
// video geometry shared by the beam timer, mixer and top level
// counter widths, rgb width and default raster timing

package video_pkg;

    // beam counter widths
    localparam int hcnt_w = 9;
    localparam int vcnt_w = 9;

    // 5:5:5 colour out of the mixer
    localparam int rgb_w = 15;

    // raster in pixels per line and lines per frame
    localparam int def_h_total = 384;
    localparam int def_v_total = 262;

    // active window
    localparam int def_h_start = 16;  // first visible pixel
    localparam int def_h_end   = 336; // one past last visible pixel
    localparam int def_v_start = 16;
    localparam int def_v_end   = 240;

    // 320x224 visible area with the defaults

endpackage

// ==== tile_pkg.sv ====
// tile data formats for the character layer
// tile map word layout, pixel width and memory address widths

package tile_pkg;

    // address widths of the three memories (word addresses)
    localparam int vram_aw  = 11; // 32 rows x 64 columns
    localparam int glyph_aw = 13; // char_addr width, bit 0 always zero
    localparam int pal_aw   = 7;  // 128 palette entries

    // layer pixel is attr plus three plane bits
    localparam int pxl_w = 7;

    // cpu side of a tile map word
    typedef struct packed {
        logic [7:0] hi; // upper byte lane, dsn[1]
        logic [7:0] lo; // lower byte lane, dsn[0]
    } tile_raw_t;

    // layer side of the same word
    typedef struct packed {
        logic [3:0] spare;
        logic [3:0] attr;  // bit 3 priority, bits 2:0 palette bank
        logic [7:0] code;  // glyph number
    } tile_fields_t;

    typedef union packed {
        tile_raw_t    raw;
        tile_fields_t fields;
    } tile_word_u;

endpackage

// ==== video_timer.sv ====
// video timer for the tilemap subsystem
// pixel clock enables, beam counters and blanking flags
`timescale 1ns/1ps

module video_timer
    import video_pkg::*;
#(
    parameter int h_total = def_h_total,
    parameter int v_total = def_v_total,
    parameter int h_start = def_h_start,
    parameter int h_end   = def_h_end,
    parameter int v_start = def_v_start,
    parameter int v_end   = def_v_end
) (
    input  logic              clk,
    input  logic              rst,
    output logic              pxl2_cen, // every second clk
    output logic              pxl_cen,  // every fourth clk
    output logic [hcnt_w-1:0] hdump,
    output logic [vcnt_w-1:0] vdump,
    output logic              hblank,
    output logic              vblank
);

    logic [1:0]        ph;     // clock phase within a pixel
    logic [hcnt_w-1:0] h_nxt;
    logic [vcnt_w-1:0] v_nxt;
    logic              h_wrap;
    logic              v_wrap;

    // clock divider
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ph       <= 2'd0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            ph       <= ph + 2'd1;
            pxl2_cen <= ph[0];
            pxl_cen  <= (ph == 2'd3); // coincides with pxl2_cen
        end
    end

    assign h_wrap = (hdump == hcnt_w'(h_total - 1));
    assign v_wrap = (vdump == vcnt_w'(v_total - 1));

    // next beam position, only taken at pxl_cen
    assign h_nxt = h_wrap ? '0 : hdump + 1'b1;
    always_comb begin
        v_nxt = vdump;
        if (h_wrap) begin
            v_nxt = v_wrap ? '0 : vdump + 1'b1;
        end
    end

    // counters and blanks move together so the flags line up with hdump
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hdump  <= '0;
            vdump  <= '0;
            hblank <= 1'b1;
            vblank <= 1'b1;
        end else if (pxl_cen) begin
            hdump  <= h_nxt;
            vdump  <= v_nxt;
            hblank <= !(h_nxt >= hcnt_w'(h_start) && h_nxt < hcnt_w'(h_end));
            vblank <= !(v_nxt >= vcnt_w'(v_start) && v_nxt < vcnt_w'(v_end));
        end
    end

endmodule

// ==== char_vram.sv ====
// tile map ram, 2048 words of 16 bits
// byte lane cpu port and a read only scan port, both registered
`timescale 1ns/1ps

module char_vram
    import tile_pkg::*;
(
    input  logic               clk,
    input  logic [vram_aw-1:0] cpu_addr,
    input  logic [15:0]        cpu_dout,
    input  logic [1:0]         we,        // byte enables, bit 1 is upper
    output logic [15:0]        cpu_q,
    input  logic [vram_aw-1:0] scan_addr,
    output logic [15:0]        scan
);

    logic [15:0] mem [1 << vram_aw];
    tile_word_u  wr_word;

    assign wr_word = cpu_dout; // cpu sees the raw byte view

    // port a, cpu
    always_ff @(posedge clk) begin
        if (we[1]) begin
            mem[cpu_addr][15:8] <= wr_word.raw.hi;
        end
        if (we[0]) begin
            mem[cpu_addr][7:0] <= wr_word.raw.lo;
        end
        cpu_q <= mem[cpu_addr]; // old data on a write cycle
    end

    // port b, video scan
    always_ff @(posedge clk) begin
        scan <= mem[scan_addr];
    end

endmodule

// ==== char_layer.sv ====
// character tilemap layer
// scans the tile map, fetches glyph rows and shifts out 7 bit pixels
`timescale 1ns/1ps

module char_layer
    import video_pkg::*, tile_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                pxl_cen,

    input  logic [vcnt_w-1:0]   vdump,
    input  logic [hcnt_w-1:0]   hdump,

    // cpu side
    input  logic                char_cs,
    input  logic [11:1]         cpu_addr,
    input  logic [15:0]         cpu_dout,
    input  logic [1:0]          dsn,
    output logic [15:0]         cpu_din,

    // glyph fetch
    input  logic                char_ok,
    output logic [glyph_aw-1:0] char_addr,
    input  logic [31:0]         char_data,

    output logic [pxl_w-1:0]    pxl
);

    logic [1:0]         we;
    logic [vram_aw-1:0] scan_addr;
    logic [15:0]        scan;
    tile_word_u         tile;
    logic [7:0]         code;
    logic [3:0]         attr0;     // attr of the group being fetched
    logic [3:0]         attr;      // attr of the group on screen
    logic [23:0]        pat_buf;   // fetched glyph row, three planes
    logic [7:0]         plane2;
    logic [7:0]         plane1;
    logic [7:0]         plane0;

    assign we = ~dsn & {2{char_cs}};

    char_vram u_vram (
        .clk       (clk),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .we        (we),
        .cpu_q     (cpu_din),
        .scan_addr (scan_addr),
        .scan      (scan)
    );

    // row of tiles from vdump, column group from hdump
    assign scan_addr = {vdump[7:3], hdump[8:3]};
    assign tile      = scan;
    assign char_addr = {1'b0, code, vdump[2:0], 1'b0}; // 8 rows of 32 bits per code

    // hold the glyph row as soon as the pattern ram reports it
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pat_buf <= '0;
        end else if (char_ok) begin
            pat_buf <= char_data[23:0]; // top byte unused
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            code   <= '0;
            attr0  <= '0;
            attr   <= '0;
            plane2 <= '0;
            plane1 <= '0;
            plane0 <= '0;
        end else if (pxl_cen) begin
            if (hdump[2:0] == 3'd4) begin
                // fetch point, latch this group and show the previous one
                code   <= tile.fields.code;
                attr0  <= tile.fields.attr;
                attr   <= attr0;
                plane2 <= pat_buf[23:16];
                plane1 <= pat_buf[15:8];
                plane0 <= pat_buf[7:0];
            end else begin
                plane2 <= plane2 << 1; // msb first
                plane1 <= plane1 << 1;
                plane0 <= plane0 << 1;
            end
        end
    end

    assign pxl = {attr, plane2[7], plane1[7], plane0[7]};

endmodule

// ==== glyph_ram.sv ====
// glyph pattern ram, stands in for the sdram graphics port
// 4096 words of 32 bits, cpu halfword access, registered video read
`timescale 1ns/1ps

module glyph_ram
    import tile_pkg::*;
(
    input  logic                clk,
    input  logic                glyph_cs,
    input  logic [13:1]         cpu_addr,  // bit 1 low selects the upper half
    input  logic [15:0]         cpu_dout,
    input  logic [1:0]          dsn,
    output logic [15:0]         cpu_din,
    input  logic [glyph_aw-1:0] char_addr,
    output logic [31:0]         char_data,
    output logic                char_ok
);

    logic [31:0]         mem [1 << (glyph_aw - 1)];
    logic [1:0]          lanes;
    logic [3:0]          we;
    logic [11:0]         cpu_word;
    logic [glyph_aw-1:0] last_addr; // address behind char_data

    assign cpu_word = cpu_addr[13:2];
    assign lanes    = ~dsn & {2{glyph_cs}};
    assign we       = cpu_addr[1] ? {2'b00, lanes} : {lanes, 2'b00};

    // cpu port
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
                mem[cpu_word][i*8 +: 8] <= cpu_dout[(i % 2)*8 +: 8];
            end
        end
        cpu_din <= cpu_addr[1] ? mem[cpu_word][15:0] : mem[cpu_word][31:16];
    end

    // video port
    always_ff @(posedge clk) begin
        char_data <= mem[char_addr[glyph_aw-1:1]];
        last_addr <= char_addr;
        char_ok   <= (char_addr != last_addr); // new row just landed
    end

endmodule

// ==== color_mixer.sv ====
// palette mixer, 7 bit layer pixels to 15 bit rgb
// plane value zero shows the backdrop, blanking forces black
`timescale 1ns/1ps

module color_mixer
    import video_pkg::*, tile_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              pxl_cen,
    input  logic              hblank,
    input  logic              vblank,
    input  logic [pxl_w-1:0]  pxl,

    // cpu side
    input  logic              pal_cs,
    input  logic [7:1]        cpu_addr,
    input  logic [15:0]       cpu_dout,
    input  logic [1:0]        dsn,
    output logic [15:0]       cpu_din,

    output logic [rgb_w-1:0]  rgb,
    output logic              blank
);

    logic [rgb_w-1:0]  pal [1 << pal_aw];
    logic [rgb_w-1:0]  cpu_q;
    logic [pal_aw-1:0] pal_idx;
    logic              blank_in;

    // cpu writes, upper lane only has 7 colour bits
    always_ff @(posedge clk) begin
        if (pal_cs && !dsn[1]) begin
            pal[cpu_addr][rgb_w-1:8] <= cpu_dout[rgb_w-1:8];
        end
        if (pal_cs && !dsn[0]) begin
            pal[cpu_addr][7:0] <= cpu_dout[7:0];
        end
        cpu_q <= pal[cpu_addr];
    end

    assign cpu_din = {{(16 - rgb_w){1'b0}}, cpu_q};

    // transparent pixels fall through to entry 0
    assign pal_idx  = (pxl[2:0] == 3'd0) ? '0 : pxl;
    assign blank_in = hblank | vblank;

    // output stage, one pixel behind pxl
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rgb   <= '0;
            blank <= 1'b1;
        end else if (pxl_cen) begin
            blank <= blank_in;
            if (blank_in) begin
                rgb <= '0;
            end else begin
                rgb <= pal[pal_idx];
            end
        end
    end

endmodule

// ==== tilemap_video.sv ====
// character tilemap video subsystem, top level
// cpu region decode, read back mux and the video pipeline
`timescale 1ns/1ps

module tilemap_video
    import video_pkg::*, tile_pkg::*;
#(
    parameter int h_total = def_h_total,
    parameter int v_total = def_v_total,
    parameter int h_start = def_h_start,
    parameter int h_end   = def_h_end,
    parameter int v_start = def_v_start,
    parameter int v_end   = def_v_end
) (
    input  logic              clk,
    input  logic              rst,

    // host bus
    input  logic              cpu_cs,
    input  logic [15:1]       cpu_addr,
    input  logic [15:0]       cpu_dout,
    input  logic [1:0]        dsn,       // byte strobes, active low
    output logic [15:0]       cpu_din,

    // video out
    output logic              pxl_cen,
    output logic [hcnt_w-1:0] hdump,
    output logic [vcnt_w-1:0] vdump,
    output logic [rgb_w-1:0]  rgb,
    output logic              blank
);

    logic [1:0]          region;
    logic [1:0]          rd_sel;   // region of the previous cycle
    logic                char_cs;
    logic                glyph_cs;
    logic                pal_cs;
    logic [15:0]         char_din;
    logic [15:0]         glyph_din;
    logic [15:0]         pal_din;
    logic                hblank;
    logic                vblank;
    logic                char_ok;
    logic [glyph_aw-1:0] char_addr;
    logic [31:0]         char_data;
    logic [pxl_w-1:0]    pxl;

    // 00 tile map, 01 glyphs, 10 palette, 11 nothing
    assign region   = cpu_addr[15:14];
    assign char_cs  = cpu_cs && (region == 2'b00);
    assign glyph_cs = cpu_cs && (region == 2'b01);
    assign pal_cs   = cpu_cs && (region == 2'b10);

    // rams answer one clk later so the mux follows the registered region
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rd_sel <= 2'b11;
        end else begin
            rd_sel <= cpu_cs ? region : 2'b11;
        end
    end

    always_comb begin
        case (rd_sel)
            2'b00:   cpu_din = char_din;
            2'b01:   cpu_din = glyph_din;
            2'b10:   cpu_din = pal_din;
            default: cpu_din = 16'h0000;
        endcase
    end

    video_timer #(
        .h_total (h_total),
        .v_total (v_total),
        .h_start (h_start),
        .h_end   (h_end),
        .v_start (v_start),
        .v_end   (v_end)
    ) u_timer (
        .clk      (clk),
        .rst      (rst),
        .pxl2_cen (),       // no 2x consumer in this subsystem
        .pxl_cen  (pxl_cen),
        .hdump    (hdump),
        .vdump    (vdump),
        .hblank   (hblank),
        .vblank   (vblank)
    );

    char_layer u_char (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .vdump     (vdump),
        .hdump     (hdump),
        .char_cs   (char_cs),
        .cpu_addr  (cpu_addr[11:1]),
        .cpu_dout  (cpu_dout),
        .dsn       (dsn),
        .cpu_din   (char_din),
        .char_ok   (char_ok),
        .char_addr (char_addr),
        .char_data (char_data),
        .pxl       (pxl)
    );

    glyph_ram u_glyph (
        .clk       (clk),
        .glyph_cs  (glyph_cs),
        .cpu_addr  (cpu_addr[13:1]),
        .cpu_dout  (cpu_dout),
        .dsn       (dsn),
        .cpu_din   (glyph_din),
        .char_addr (char_addr),
        .char_data (char_data),
        .char_ok   (char_ok)
    );

    color_mixer u_mixer (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .hblank   (hblank),
        .vblank   (vblank),
        .pxl      (pxl),
        .pal_cs   (pal_cs),
        .cpu_addr (cpu_addr[7:1]),
        .cpu_dout (cpu_dout),
        .dsn      (dsn),
        .cpu_din  (pal_din),
        .rgb      (rgb),
        .blank    (blank)
    );

endmodule

// ==== tb_tilemap_video.sv ====
// testbench for the tilemap video subsystem
// cpu bus tasks, shadow memories and a per pixel rgb reference
`timescale 1ns/1ps

module tb_tilemap_video
    import video_pkg::*, tile_pkg::*;
#(
    parameter int h_total = def_h_total,
    parameter int h_start = def_h_start,
    parameter int h_end   = def_h_end,
    parameter int v_total = def_v_total,
    parameter int v_start = def_v_start,
    parameter int v_end   = def_v_end
);

    localparam int gw_aw       = glyph_aw - 1;  // glyph word index width
    localparam int vram_words  = 1 << vram_aw;
    localparam int glyph_words = 1 << gw_aw;
    localparam int pal_entries = 1 << pal_aw;
    localparam int active_px   = (h_end - h_start) * (v_end - v_start);
    // 4 clk per pixel, load is two clk per bus access plus slack
    localparam int frame_clks  = h_total * v_total * 4;
    localparam int load_clks   = 2 * (vram_words + 2 * glyph_words + pal_entries) + 2000;
    localparam int timeout_ns  = (3 * frame_clks + load_clks) * 4;

    logic              clk = 1'b0;
    logic              rst;
    logic              cpu_cs;
    logic [15:1]       cpu_addr;
    logic [15:0]       cpu_dout;
    logic [1:0]        dsn;
    logic [15:0]       cpu_din;
    logic              pxl_cen;
    logic [hcnt_w-1:0] hdump;
    logic [vcnt_w-1:0] vdump;
    logic [rgb_w-1:0]  rgb;
    logic              blank;

    // shadow copies of the three memories
    logic [15:0]       vram_sh  [vram_words];
    logic [31:0]       glyph_sh [glyph_words];
    logic [rgb_w-1:0]  pal_sh   [pal_entries];

    int                err_cnt = 0;
    int                chk_cnt = 0;
    int                active_cnt = 0;
    int                trans_early = 0;  // backdrop pixels seen, first frame
    int                trans_late = 0;   // same after backdrop change
    logic              check_on;
    logic              second_frame;

    // expected beam position and clk count between pixel enables
    logic [hcnt_w-1:0] beam_h;
    logic [vcnt_w-1:0] beam_v;
    int                cen_gap;
    logic              cen_seen;

    always #2 clk = ~clk;

    tilemap_video #(
        .h_total (h_total),
        .v_total (v_total),
        .h_start (h_start),
        .h_end   (h_end),
        .v_start (v_start),
        .v_end   (v_end)
    ) dut_i (
        .clk      (clk),
        .rst      (rst),
        .cpu_cs   (cpu_cs),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .dsn      (dsn),
        .cpu_din  (cpu_din),
        .pxl_cen  (pxl_cen),
        .hdump    (hdump),
        .vdump    (vdump),
        .rgb      (rgb),
        .blank    (blank)
    );

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // cpu word addresses per region
    function automatic logic [15:1] vram_loc(input logic [vram_aw-1:0] idx);
        return {2'b00, 2'b00, idx};
    endfunction

    function automatic logic [15:1] glyph_loc(input logic [gw_aw-1:0] w, input logic lo_half);
        return {2'b01, w, lo_half};  // bit 1 set is the low half
    endfunction

    function automatic logic [15:1] pal_loc(input logic [pal_aw-1:0] idx);
        return {2'b10, 6'd0, idx};
    endfunction

    // one bus write, shadow follows the byte strobes
    task automatic cpu_write(input logic [15:1] addr, input logic [15:0] data,
                             input logic [1:0] strobes);
        logic [31:0] gw;
        @(negedge clk);
        cpu_cs   = 1'b1;
        cpu_addr = addr;
        cpu_dout = data;
        dsn      = strobes;
        case (addr[15:14])
            2'b00: begin
                if (!strobes[1]) vram_sh[addr[11:1]][15:8] = data[15:8];
                if (!strobes[0]) vram_sh[addr[11:1]][7:0] = data[7:0];
            end
            2'b01: begin
                gw = glyph_sh[addr[13:2]];
                if (addr[1]) begin
                    if (!strobes[1]) gw[15:8] = data[15:8];
                    if (!strobes[0]) gw[7:0] = data[7:0];
                end else begin
                    if (!strobes[1]) gw[31:24] = data[15:8];
                    if (!strobes[0]) gw[23:16] = data[7:0];
                end
                glyph_sh[addr[13:2]] = gw;
            end
            2'b10: begin
                if (!strobes[1]) pal_sh[addr[7:1]][14:8] = data[14:8];  // 7 colour bits up top
                if (!strobes[0]) pal_sh[addr[7:1]][7:0] = data[7:0];
            end
            default: ;  // region 11 holds nothing
        endcase
        @(negedge clk);
        cpu_cs = 1'b0;
        dsn    = 2'b11;
    endtask

    task automatic cpu_read(input logic [15:1] addr, output logic [15:0] data);
        @(negedge clk);
        cpu_cs   = 1'b1;
        cpu_addr = addr;
        dsn      = 2'b11;
        @(negedge clk);  // data one clk after the address
        data   = cpu_din;
        cpu_cs = 1'b0;
    endtask

    function automatic logic [15:0] expect_read(input logic [15:1] addr);
        case (addr[15:14])
            2'b00:   return vram_sh[addr[11:1]];
            2'b01:   return addr[1] ? glyph_sh[addr[13:2]][15:0] : glyph_sh[addr[13:2]][31:16];
            2'b10:   return {1'b0, pal_sh[addr[7:1]]};
            default: return 16'h0000;
        endcase
    endfunction

    task automatic read_check(input logic [15:1] addr, input string what);
        logic [15:0] got;
        cpu_read(addr, got);
        check_eq(32'(got), 32'(expect_read(addr)), $sformatf("%s at %h", what, addr));
    endtask

    // blank flag trails the beam by one pixel
    function automatic logic in_blank(input logic [hcnt_w-1:0] h, input logic [vcnt_w-1:0] v);
        int hp;
        int vi;
        hp = 32'(h) - 1;
        vi = 32'(v);
        return (hp < h_start) || (hp >= h_end) || (vi < v_start) || (vi >= v_end);
    endfunction

    // palette index of tile pixel h-14 on row v
    function automatic logic [pal_aw-1:0] ref_index(input logic [hcnt_w-1:0] h,
                                                     input logic [vcnt_w-1:0] v);
        logic [hcnt_w-1:0] p;
        tile_word_u        t;
        logic [31:0]       gw;
        logic [7:0]        pl2;
        logic [7:0]        pl1;
        logic [7:0]        pl0;
        logic [2:0]        sel;
        logic [2:0]        bits;
        p   = h - 9'd14;
        t   = vram_sh[{v[7:3], p[8:3]}];
        gw  = glyph_sh[{1'b0, t.fields.code, v[2:0]}];
        pl2 = gw[23:16];
        pl1 = gw[15:8];
        pl0 = gw[7:0];
        sel = 3'd7 - p[2:0];  // leftmost pixel is the msb
        bits = {pl2[sel], pl1[sel], pl0[sel]};
        return (bits == 3'b000) ? 7'd0 : {t.fields.attr, bits};  // backdrop
    endfunction

    function automatic logic [rgb_w-1:0] ref_rgb(input logic [hcnt_w-1:0] h,
                                                 input logic [vcnt_w-1:0] v);
        if (in_blank(h, v)) begin
            return '0;
        end
        return pal_sh[ref_index(h, v)];
    endfunction

    // pixel compare, outputs are steady at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            beam_h   = '0;
            beam_v   = '0;
            cen_gap  = 0;
            cen_seen = 1'b0;
        end else begin
            cen_gap++;
            if (pxl_cen) begin
                if (cen_seen) begin
                    check_eq(32'(cen_gap), 32'd4, "pixel enable spacing");
                end
                cen_gap  = 0;
                cen_seen = 1'b1;
                check_eq(32'(hdump), 32'(beam_h), "hdump position");
                check_eq(32'(vdump), 32'(beam_v), "vdump position");
                if (in_blank(hdump, vdump)) begin
                    check_eq(32'(rgb), 32'd0,
                             $sformatf("rgb in blanking h=%0d v=%0d", hdump, vdump));
                    check_eq(32'(blank), 32'd1,
                             $sformatf("blank flag h=%0d v=%0d", hdump, vdump));
                end else if (check_on) begin
                    check_eq(32'(rgb), 32'(ref_rgb(hdump, vdump)),
                             $sformatf("rgb at h=%0d v=%0d", hdump, vdump));
                    check_eq(32'(blank), 32'd0,
                             $sformatf("blank flag h=%0d v=%0d", hdump, vdump));
                    active_cnt++;
                    if (ref_index(hdump, vdump) == 7'd0 && rgb === pal_sh[0]) begin
                        if (second_frame) trans_late++;
                        else trans_early++;
                    end
                end
                // one pixel per enable, wrap per line and per frame
                if (beam_h == hcnt_w'(h_total - 1)) begin
                    beam_h = '0;
                    if (beam_v == vcnt_w'(v_total - 1)) begin
                        beam_v = '0;
                    end else begin
                        beam_v = beam_v + 1'b1;
                    end
                end else begin
                    beam_h = beam_h + 1'b1;
                end
            end
        end
    end

    task automatic wait_frame_start();
        do begin
            @(negedge clk);
        end while (!(pxl_cen && hdump == 9'd0 && vdump == 9'd0));
    endtask

    task automatic test_byte_lanes();
        logic [vram_aw-1:0] a;
        repeat (4) begin
            a = vram_aw'($urandom);
            cpu_write(vram_loc(a), 16'($urandom), 2'b00);
            read_check(vram_loc(a), "tile map full word");
            cpu_write(vram_loc(a), 16'($urandom), 2'b10);  // low byte only
            read_check(vram_loc(a), "tile map low lane");
            cpu_write(vram_loc(a), 16'($urandom), 2'b01);  // high byte only
            read_check(vram_loc(a), "tile map high lane");
            cpu_write(vram_loc(a), 16'($urandom), 2'b11);  // no strobe, no change
            read_check(vram_loc(a), "tile map no lane");
        end
    endtask

    task automatic test_readback();
        logic [gw_aw-1:0]  w;
        logic [pal_aw-1:0] pi;
        logic              half;
        logic [15:1]       odd;
        repeat (8) begin
            w    = gw_aw'($urandom);
            half = 1'($urandom);
            cpu_write(glyph_loc(w, half), 16'($urandom), 2'($urandom));
            read_check(glyph_loc(w, half), "glyph half");
            pi = pal_aw'($urandom);
            cpu_write(pal_loc(pi), 16'($urandom), 2'b00);
            read_check(pal_loc(pi), "palette entry");
            odd = {2'b11, 13'($urandom)};
            cpu_write(odd, 16'($urandom), 2'b00);
            read_check(odd, "unmapped region");
        end
    endtask

    // random memories, about a quarter of glyph rows have no planes set
    task automatic load_random();
        logic [31:0] gw;
        for (int i = 0; i < vram_words; i++) begin
            cpu_write(vram_loc(vram_aw'(i)), 16'($urandom), 2'b00);
        end
        for (int i = 0; i < glyph_words; i++) begin
            gw = $urandom;
            if (($urandom & 32'd3) == 32'd0) gw[23:0] = '0;
            cpu_write(glyph_loc(gw_aw'(i), 1'b0), gw[31:16], 2'b00);
            cpu_write(glyph_loc(gw_aw'(i), 1'b1), gw[15:0], 2'b00);
        end
        for (int i = 0; i < pal_entries; i++) begin
            cpu_write(pal_loc(pal_aw'(i)), 16'($urandom), 2'b00);
        end
    endtask

    initial begin
        void'($urandom(32'he83d_46b8));
        rst          = 1'b1;
        cpu_cs       = 1'b0;
        cpu_addr     = '0;
        cpu_dout     = '0;
        dsn          = 2'b11;
        check_on     = 1'b0;
        second_frame = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        check_eq(32'(blank), 32'd1, "blank right after reset");
        check_eq(32'(rgb), 32'd0, "rgb right after reset");
        test_byte_lanes();
        test_readback();
        load_random();
        wait_frame_start();
        check_on = 1'b1;
        wait_frame_start();
        second_frame = 1'b1;
        // new backdrop while still in vblank
        cpu_write(pal_loc(7'd0), {1'b0, pal_sh[0] ^ 15'h7fff}, 2'b00);
        wait_frame_start();
        check_on = 1'b0;
        check_eq(32'(active_cnt), 32'(2 * active_px), "active pixels compared");
        check_eq(32'(trans_early > 0), 32'd1, "backdrop pixels in first frame");
        check_eq(32'(trans_late > 0), 32'd1, "backdrop pixels after entry 0 change");
        $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog, three frames plus the memory load
    initial begin
        #(timeout_ns);
        $display("timeout: the run did not end within %0d ns", timeout_ns);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== list.f ====
video_pkg.sv
tile_pkg.sv
video_timer.sv
char_vram.sv
char_layer.sv
glyph_ram.sv
color_mixer.sv
tilemap_video.sv
tb_tilemap_video.sv

// ==== Makefile ====
# verilator build and run of the tilemap video testbench
TOP := tb_tilemap_video

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f list.f -Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
